// File: include/desc_settings.svh
`ifndef DESC_SETTINGS_SVH
`define DESC_SETTINGS_SVH

// Buffer word address and metadata widths
`define DESC_ADDR_WID 10
`define DESC_META_WID 4

// Largest legal packet in bytes
`define DESC_MAX_PKT_SIZE 16383

// Bytes carried by one write side beat
`define DESC_BEAT_BYTES 8

// Default number of descriptor FIFO entries as a power of two
`define DESC_FIFO_DEPTH 8

`endif

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module desc_path_tb \
    --Mdir obj_dir \
    -o desc_path_sim

./obj_dir/desc_path_sim

// File: tb.f
+incdir+include
verilog/desc_pkg.sv
verilog/desc_builder.sv
verilog/desc_fifo.sv
verilog/desc_dispatch.sv
verilog/desc_path_top.sv
tb/desc_path_assert.sv
tb/desc_path_tb.sv

// File: tb/desc_path_assert.sv
`timescale 1ns/1ps
`include "desc_settings.svh"

module desc_path_assert (
    input logic                      clk,
    input logic                      rst,
    input logic                      push,
    input logic                      full,
    input logic                      pop,
    input logic                      empty,
    input logic                      out_vld,
    input logic                      out_rdy,
    input logic [`DESC_ADDR_WID-1:0] out_addr,
    input desc_pkg::size_t           out_size,
    input logic [`DESC_META_WID-1:0] out_meta,
    input logic [31:0]               pkt_cnt
);

    // Nothing moves while in reset
    assert property (@(posedge clk) rst |=> (!out_vld && !push && !pop))
        else $error("out_vld, push or pop high during reset");

    // Stalled output keeps its payload
    assert property (@(posedge clk) disable iff (rst)
        (out_vld && !out_rdy) |=> (out_vld && $stable(out_addr)
                                   && $stable(out_size) && $stable(out_meta)))
        else $error("output changed while stalled");

    assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("push into a full FIFO");

    assert property (@(posedge clk) disable iff (rst) !(pop && empty))
        else $error("pop from an empty FIFO");

    assert property (@(posedge clk) disable iff (rst)
        (out_vld && out_rdy) |=> (pkt_cnt == $past(pkt_cnt) + 32'd1))
        else $error("pkt_cnt did not follow a transfer");

endmodule

bind desc_path_top desc_path_assert u_assert (
    .clk      (clk),
    .rst      (rst),
    .push     (push),
    .full     (full),
    .pop      (pop),
    .empty    (empty),
    .out_vld  (out_vld),
    .out_rdy  (out_rdy),
    .out_addr (out_addr),
    .out_size (out_size),
    .out_meta (out_meta),
    .pkt_cnt  (pkt_cnt)
);

// File: tb/desc_path_tb.sv
`timescale 1ns/1ps
`include "desc_settings.svh"

module desc_path_tb;

    localparam int NUM_PKTS = 200;
    localparam int OVERSIZE_PKT = 50;
    localparam int STALL_FIRST = 120;
    localparam int STALL_LAST = 139;
    localparam longint WATCHDOG_NS = longint'(NUM_PKTS) * 300 * 40 + 10 * 40;

    logic                      clk;
    logic                      rst;
    logic                      beat_vld;
    logic                      beat_sop;
    logic                      beat_eop;
    logic [3:0]                beat_bytes;
    logic                      beat_err;
    logic [`DESC_META_WID-1:0] beat_meta;
    logic                      out_rdy;
    logic                      out_vld;
    logic [`DESC_ADDR_WID-1:0] out_addr;
    desc_pkg::size_t           out_size;
    logic [`DESC_META_WID-1:0] out_meta;
    logic [31:0]               pkt_cnt;
    logic [31:0]               byte_cnt;
    logic [31:0]               err_cnt;
    logic [31:0]               ovf_cnt;

    int seed = 32'h7a4f;
    bit stall;

    // Reference model state
    int                        m_ptr;
    int                        m_start;
    int                        m_size;
    bit                        m_err;
    logic [`DESC_META_WID-1:0] m_meta;
    bit                        m_pend;
    desc_pkg::desc_t           m_pend_desc;
    desc_pkg::desc_t           m_fifo[$];
    bit                        m_outv;
    desc_pkg::desc_t           m_out;
    logic [31:0]               m_pkts;
    logic [31:0]               m_bytes;
    logic [31:0]               m_errs;
    logic [31:0]               m_drops;

    desc_path_top dut (
        .clk        (clk),
        .rst        (rst),
        .beat_vld   (beat_vld),
        .beat_sop   (beat_sop),
        .beat_eop   (beat_eop),
        .beat_bytes (beat_bytes),
        .beat_err   (beat_err),
        .beat_meta  (beat_meta),
        .out_rdy    (out_rdy),
        .out_vld    (out_vld),
        .out_addr   (out_addr),
        .out_size   (out_size),
        .out_meta   (out_meta),
        .pkt_cnt    (pkt_cnt),
        .byte_cnt   (byte_cnt),
        .err_cnt    (err_cnt),
        .ovf_cnt    (ovf_cnt)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the packet stream did not drain in time");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    task automatic check_value(input string name, input longint got, input longint exp);
        assert (got == exp)
        else
        begin
            $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_state();
        check_value("out_vld", longint'(out_vld), longint'(m_outv));
        check_value("pkt_cnt", longint'(pkt_cnt), longint'(m_pkts));
        check_value("byte_cnt", longint'(byte_cnt), longint'(m_bytes));
        check_value("err_cnt", longint'(err_cnt), longint'(m_errs));
        check_value("ovf_cnt", longint'(ovf_cnt), longint'(m_drops));
    endtask

    // Model state after the coming rising edge
    task automatic advance_model(input logic vld, input logic sop, input logic eop,
                                 input logic [3:0] nbytes, input logic err,
                                 input logic [`DESC_META_WID-1:0] meta, input logic rdy);
        desc_pkg::desc_t head;
        bit push_now;
        bit pop_now;
        bit xfer;
        push_now = 1'b0;
        if (m_pend)
        begin
            if (m_fifo.size() == `DESC_FIFO_DEPTH)
                m_drops = m_drops + 32'd1;
            else
                push_now = 1'b1;
        end
        pop_now = (m_fifo.size() != 0) && (!m_outv || rdy);
        xfer = m_outv && rdy;
        if (xfer)
        begin
            m_pkts = m_pkts + 32'd1;
            m_bytes = m_bytes + 32'(m_out.size);
            m_outv = 1'b0;
        end
        if (pop_now)
        begin
            head = m_fifo.pop_front();
            if (head.err)
                m_errs = m_errs + 32'd1;
            else
            begin
                m_out = head;
                m_outv = 1'b1;
            end
        end
        if (push_now)
            m_fifo.push_back(m_pend_desc);

        m_pend = 1'b0;
        if (vld)
        begin
            if (sop)
            begin
                m_start = m_ptr;
                m_size = 0;
                m_err = 1'b0;
                m_meta = meta;
            end
            m_err = m_err | err;
            if (eop)
            begin
                m_size = m_size + int'(nbytes);
                m_pend_desc.addr = `DESC_ADDR_WID'(m_start);
                m_pend_desc.err = m_err || (m_size > `DESC_MAX_PKT_SIZE);
                if (m_size > `DESC_MAX_PKT_SIZE)
                    m_pend_desc.size = desc_pkg::size_t'(`DESC_MAX_PKT_SIZE);
                else
                    m_pend_desc.size = desc_pkg::size_t'(m_size);
                m_pend_desc.meta = m_meta;
                m_pend = 1'b1;
            end
            else
                m_size = m_size + `DESC_BEAT_BYTES;
            m_ptr = (m_ptr + 1) % (1 << `DESC_ADDR_WID);
        end
    endtask

    task automatic run_cycle(input logic vld, input logic sop, input logic eop,
                             input logic [3:0] nbytes, input logic err,
                             input logic [`DESC_META_WID-1:0] meta);
        logic rdy;
        @(negedge clk);
        compare_state();
        rdy = stall ? 1'b0 : (rand_below(4) != 0);
        beat_vld = vld;
        beat_sop = sop;
        beat_eop = eop;
        beat_bytes = nbytes;
        beat_err = err;
        beat_meta = meta;
        out_rdy = rdy;
        // Transfer happens at the coming edge
        if (out_vld && rdy)
        begin
            check_value("out_addr", longint'(out_addr), longint'(m_out.addr));
            check_value("out_size", longint'(out_size), longint'(m_out.size));
            check_value("out_meta", longint'(out_meta), longint'(m_out.meta));
        end
        advance_model(vld, sop, eop, nbytes, err, meta, rdy);
    endtask

    task automatic send_packet(input int nbytes, input bit bad);
        int beats;
        int last;
        int bad_beat;
        int i;
        logic [`DESC_META_WID-1:0] meta;
        beats = (nbytes + `DESC_BEAT_BYTES - 1) / `DESC_BEAT_BYTES;
        last = nbytes - `DESC_BEAT_BYTES * (beats - 1);
        meta = `DESC_META_WID'(rand_below(16));
        bad_beat = bad ? rand_below(beats) : -1;
        repeat (rand_below(4))
            run_cycle(1'b0, 1'b0, 1'b0, 4'd0, 1'b0, '0);
        for (i = 0; i < beats; i++)
        begin
            if (i != 0 && rand_below(16) == 0)
                run_cycle(1'b0, 1'b0, 1'b0, 4'd0, 1'b0, '0);
            // Byte count and meta carry junk where they are not read
            run_cycle(1'b1, i == 0, i == beats - 1,
                      (i == beats - 1) ? 4'(last) : 4'(rand_below(16)),
                      i == bad_beat,
                      (i == 0) ? meta : `DESC_META_WID'(rand_below(16)));
        end
    endtask

    initial
    begin
        int k;
        int n;
        bit bad;
        rst = 1'b1;
        beat_vld = 1'b0;
        beat_sop = 1'b0;
        beat_eop = 1'b0;
        beat_bytes = 4'd0;
        beat_err = 1'b0;
        beat_meta = '0;
        out_rdy = 1'b0;
        stall = 1'b0;
        m_ptr = 0;
        m_start = 0;
        m_size = 0;
        m_err = 1'b0;
        m_meta = '0;
        m_pend = 1'b0;
        m_pend_desc = '0;
        m_outv = 1'b0;
        m_out = '0;
        m_pkts = '0;
        m_bytes = '0;
        m_errs = '0;
        m_drops = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (k = 0; k < NUM_PKTS; k++)
        begin
            stall = (k >= STALL_FIRST) && (k <= STALL_LAST);
            if (k == OVERSIZE_PKT)
                n = `DESC_MAX_PKT_SIZE + 7;
            else if (stall)
                n = 1 + rand_below(64);
            else
                n = 1 + rand_below(2100);
            bad = (k != OVERSIZE_PKT) && (rand_below(8) == 0);
            send_packet(n, bad);
            if (k == STALL_LAST && m_drops == 0)
            begin
                $display("The stall phase did not make the builder drop any descriptor");
                $display("Simulation finished: FAIL");
                $fatal(1, "no overflow reached");
            end
        end

        stall = 1'b0;
        while (m_pend || m_fifo.size() != 0 || m_outv)
            run_cycle(1'b0, 1'b0, 1'b0, 4'd0, 1'b0, '0);
        @(negedge clk);
        compare_state();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: verilog/desc_builder.sv
`timescale 1ns/1ps
`include "desc_settings.svh"

module desc_builder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      beat_vld,
    input  logic                      beat_sop,
    input  logic                      beat_eop,
    input  logic [3:0]                beat_bytes,
    input  logic                      beat_err,
    input  logic [`DESC_META_WID-1:0] beat_meta,
    input  logic                      full,
    output logic                      push,
    output desc_pkg::desc_t           push_desc,
    output logic [31:0]               ovf_cnt
);

    // One extra bit to see a size past the maximum
    localparam int TOT_WID = desc_pkg::SIZE_WID + 1;

    logic [`DESC_ADDR_WID-1:0] wr_ptr;
    logic [`DESC_ADDR_WID-1:0] start_addr;
    desc_pkg::size_t           run_size;
    logic                      run_ovs;
    logic                      run_err;
    logic [`DESC_META_WID-1:0] run_meta;
    logic                      desc_pend;

    logic [`DESC_ADDR_WID-1:0] cur_addr;
    desc_pkg::size_t           cur_base;
    logic                      cur_err;
    logic [`DESC_META_WID-1:0] cur_meta;
    logic [TOT_WID-1:0]        cur_total;
    logic                      cur_ovs;

    // Packet state including the current beat; sop starts afresh
    always_comb
    begin
        cur_addr = beat_sop ? wr_ptr : start_addr;
        cur_base = beat_sop ? '0 : run_size;
        cur_err  = beat_err | (~beat_sop & run_err);
        cur_meta = beat_sop ? beat_meta : run_meta;
        if (beat_eop)
            cur_total = {1'b0, cur_base} + TOT_WID'(beat_bytes);
        else
            cur_total = {1'b0, cur_base} + TOT_WID'(`DESC_BEAT_BYTES);
        cur_ovs = (~beat_sop & run_ovs) | (cur_total > TOT_WID'(`DESC_MAX_PKT_SIZE));
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr    <= '0;
            desc_pend <= 1'b0;
            ovf_cnt   <= '0;
        end
        else
        begin
            // Word pointer wraps with the buffer
            if (beat_vld)
                wr_ptr <= wr_ptr + 1'b1;
            desc_pend <= beat_vld & beat_eop;
            if (desc_pend & full)
                ovf_cnt <= ovf_cnt + 32'd1;
        end
    end

    // Running packet state and the finished descriptor
    always_ff @(posedge clk)
    begin
        if (beat_vld)
        begin
            if (beat_eop)
            begin
                push_desc.addr <= cur_addr;
                push_desc.size <= cur_ovs ? desc_pkg::MAX_SIZE
                                          : cur_total[desc_pkg::SIZE_WID-1:0];
                push_desc.err  <= cur_err | cur_ovs;
                push_desc.meta <= cur_meta;
            end
            else
            begin
                start_addr <= cur_addr;
                run_size   <= cur_ovs ? desc_pkg::MAX_SIZE
                                      : cur_total[desc_pkg::SIZE_WID-1:0];
                run_ovs    <= cur_ovs;
                run_err    <= cur_err;
                run_meta   <= cur_meta;
            end
        end
    end

    // Finished descriptor is dropped when the FIFO is full
    assign push = desc_pend & ~full;

endmodule

// File: verilog/desc_dispatch.sv
`timescale 1ns/1ps
`include "desc_settings.svh"

module desc_dispatch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      empty,
    input  desc_pkg::desc_t           head_desc,
    input  logic                      out_rdy,
    output logic                      pop,
    output logic                      out_vld,
    output logic [`DESC_ADDR_WID-1:0] out_addr,
    output desc_pkg::size_t           out_size,
    output logic [`DESC_META_WID-1:0] out_meta,
    output logic [31:0]               pkt_cnt,
    output logic [31:0]               byte_cnt,
    output logic [31:0]               err_cnt
);

    logic xfer;
    logic out_free;
    logic load;
    logic drop;

    assign xfer     = out_vld & out_rdy;
    assign out_free = ~out_vld | out_rdy;

    // Take the head whenever the output register can accept it
    assign pop  = ~empty & out_free;
    assign load = pop & ~head_desc.err;
    assign drop = pop & head_desc.err;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_vld  <= 1'b0;
            pkt_cnt  <= '0;
            byte_cnt <= '0;
            err_cnt  <= '0;
        end
        else
        begin
            if (load)
                out_vld <= 1'b1;
            else if (xfer)
                out_vld <= 1'b0;

            // Statistics follow accepted transfers
            if (xfer)
            begin
                pkt_cnt  <= pkt_cnt + 32'd1;
                byte_cnt <= byte_cnt + 32'(out_size);
            end

            // errored heads never reach the output
            if (drop)
                err_cnt <= err_cnt + 32'd1;
        end
    end

    // Payload holds while the consumer stalls
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            out_addr <= head_desc.addr;
            out_size <= head_desc.size;
            out_meta <= head_desc.meta;
        end
    end

endmodule

// File: verilog/desc_fifo.sv
`timescale 1ns/1ps
`include "desc_settings.svh"

module desc_fifo #(
    parameter int DEPTH = `DESC_FIFO_DEPTH
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  desc_pkg::desc_t push_desc,
    input  logic            pop,
    output desc_pkg::desc_t head_desc,
    output logic            full,
    output logic            empty
);

    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = PTR_WID + 1;

    desc_pkg::desc_t    mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_desc;
    end

    // Oldest entry always on show
    assign head_desc = mem[rd_ptr];

    assign full  = (count == CNT_WID'(DEPTH));
    assign empty = (count == '0);

endmodule

// File: verilog/desc_path_top.sv
`timescale 1ns/1ps
`include "desc_settings.svh"

module desc_path_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      beat_vld,
    input  logic                      beat_sop,
    input  logic                      beat_eop,
    input  logic [3:0]                beat_bytes,
    input  logic                      beat_err,
    input  logic [`DESC_META_WID-1:0] beat_meta,
    input  logic                      out_rdy,
    output logic                      out_vld,
    output logic [`DESC_ADDR_WID-1:0] out_addr,
    output desc_pkg::size_t           out_size,
    output logic [`DESC_META_WID-1:0] out_meta,
    output logic [31:0]               pkt_cnt,
    output logic [31:0]               byte_cnt,
    output logic [31:0]               err_cnt,
    output logic [31:0]               ovf_cnt
);

    logic            push;
    logic            pop;
    logic            full;
    logic            empty;
    desc_pkg::desc_t push_desc;
    desc_pkg::desc_t head_desc;

    desc_builder u_builder (
        .clk        (clk),
        .rst        (rst),
        .beat_vld   (beat_vld),
        .beat_sop   (beat_sop),
        .beat_eop   (beat_eop),
        .beat_bytes (beat_bytes),
        .beat_err   (beat_err),
        .beat_meta  (beat_meta),
        .full       (full),
        .push       (push),
        .push_desc  (push_desc),
        .ovf_cnt    (ovf_cnt)
    );

    desc_fifo #(
        .DEPTH (`DESC_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_desc (push_desc),
        .pop       (pop),
        .head_desc (head_desc),
        .full      (full),
        .empty     (empty)
    );

    desc_dispatch u_dispatch (
        .clk       (clk),
        .rst       (rst),
        .empty     (empty),
        .head_desc (head_desc),
        .out_rdy   (out_rdy),
        .pop       (pop),
        .out_vld   (out_vld),
        .out_addr  (out_addr),
        .out_size  (out_size),
        .out_meta  (out_meta),
        .pkt_cnt   (pkt_cnt),
        .byte_cnt  (byte_cnt),
        .err_cnt   (err_cnt)
    );

endmodule

// File: verilog/desc_pkg.sv
`include "desc_settings.svh"

package desc_pkg;

    // Size field wide enough for the largest packet
    localparam int SIZE_WID = $clog2(`DESC_MAX_PKT_SIZE + 1);

    typedef logic [SIZE_WID-1:0] size_t;

    // Oversized packets report this size
    localparam size_t MAX_SIZE = size_t'(`DESC_MAX_PKT_SIZE);

    // Packet descriptor of 29 bits by default
    typedef struct packed {
        logic [`DESC_ADDR_WID-1:0] addr;
        size_t                     size;
        logic                      err;
        logic [`DESC_META_WID-1:0] meta;
    } desc_t;

endpackage
